//--- rtl/tlbMiss_config.svh
`ifndef TLBMISS_CONFIG_SVH
`define TLBMISS_CONFIG_SVH

// Miss queue slots, not counting the head register
`define TLBMISS_QUEUE_SIZE 4

// Micro-TLB entries
`define TLBMISS_TLB_SIZE 4

`define TLBMISS_SQN_WIDTH 7

// Sv32 address fields
`define TLBMISS_VPN_WIDTH 20
`define TLBMISS_PPN_WIDTH 22

// Sv32 page table entry layout
`define TLBMISS_PTE_R_BIT 1
`define TLBMISS_PTE_X_BIT 3
`define TLBMISS_PTE_PPN_LSB 10

`endif

//--- rtl/tlbMissPkg.sv
`include "tlbMiss_config.svh"

package tlbMissPkg;

    // Virtual page number from vaddr[31:12]
    typedef logic [`TLBMISS_VPN_WIDTH-1:0] Vpn;

    // Physical page number for a 34-bit physical space
    typedef logic [`TLBMISS_PPN_WIDTH-1:0] Ppn;

    typedef logic [`TLBMISS_SQN_WIDTH-1:0] SqN;

    // DONE is the result cycle of a two-level walk
    typedef enum logic [2:0] {
        IDLE,
        LEVEL1_REQ,
        LEVEL1_WAIT,
        LEVEL0_REQ,
        LEVEL0_WAIT,
        DONE
    } WalkState;

endpackage

//--- rtl/TlbMissQueue.sv
`timescale 1ns/10ps
`include "tlbMiss_config.svh"

module TlbMissQueue #(
    parameter int SIZE = `TLBMISS_QUEUE_SIZE
) (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    branchTaken,
    input  tlbMissPkg::SqN          branchSqN,
    input  logic                    pwValid,
    input  tlbMissPkg::Vpn          pwVpn,
    input  logic                    pwSuperPage,
    input  logic                    pwActive,
    input  logic                    transEnable,
    input  logic                    enqueue,
    input  logic [31:0]             enqAddr,
    input  tlbMissPkg::SqN          enqSqN,
    input  logic                    uopReady,
    input  logic                    dequeue,
    output logic [$clog2(SIZE):0]   freeCount,
    output logic                    ready,
    output logic                    headValid,
    output logic [31:0]             headAddr,
    output tlbMissPkg::SqN          headSqN
);
    localparam int IDW = $clog2(SIZE);

    logic [SIZE-1:0] slotValid;
    logic [SIZE-1:0] slotReady;
    logic [31:0] slotAddr [SIZE];
    tlbMissPkg::SqN slotSqN [SIZE];

    logic [IDW-1:0] idxIn;
    logic idxInValid;
    logic [IDW-1:0] idxOut;
    logic idxOutValid;
    logic [IDW:0] freeSlots;
    logic enqEn;
    logic headClear;
    logic issueEn;

    // Younger than the branch being resolved this cycle
    function automatic logic isFlushed(input tlbMissPkg::SqN sqN);
        tlbMissPkg::SqN diff;
        diff = sqN - branchSqN;
        return branchTaken && ($signed(diff) > 0);
    endfunction

    // Address lies on the page the walker just resolved
    function automatic logic pwMatch(input logic [31:0] addr);
        return pwSuperPage ? (pwVpn[19:10] == addr[31:22]) : (pwVpn == addr[31:12]);
    endfunction

    // Free slot for enqueue
    always_comb begin
        idxIn = '0;
        idxInValid = 1'b0;
        for (int i = 0; i < SIZE; i++) begin
            if (!slotValid[i]) begin
                idxIn = IDW'(i);
                idxInValid = 1'b1;
            end
        end
    end

    assign ready = idxInValid;

    // One slot stays reserved for a replay of the head
    always_comb begin
        freeSlots = '0;
        for (int i = 0; i < SIZE; i++) begin
            freeSlots = freeSlots + {{IDW{1'b0}}, !slotValid[i]};
        end
        freeCount = freeSlots;
        if (headValid && freeSlots != '0)
            freeCount = freeSlots - 1'b1;
    end

    // Non-ready ops may go out while the walker is idle to start the next walk
    always_comb begin
        idxOut = '0;
        idxOutValid = 1'b0;
        for (int i = 0; i < SIZE; i++) begin
            if (slotValid[i] && (slotReady[i] || !pwActive) && !isFlushed(slotSqN[i])) begin
                idxOut = IDW'(i);
                idxOutValid = 1'b1;
            end
        end
    end

    assign enqEn = enqueue && idxInValid && !isFlushed(enqSqN);
    assign headClear = dequeue || (headValid && isFlushed(headSqN));
    assign issueEn = (!headValid || headClear) && idxOutValid;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            slotValid <= '0;
            slotReady <= '0;
            headValid <= 1'b0;
        end else begin
            for (int i = 0; i < SIZE; i++) begin
                if (pwValid && slotValid[i] && pwMatch(slotAddr[i]))
                    slotReady[i] <= 1'b1;
                if (slotValid[i] && isFlushed(slotSqN[i]))
                    slotValid[i] <= 1'b0;
            end

            if (enqEn) begin
                slotValid[idxIn] <= 1'b1;
                // Catch a walk result arriving together with the op
                slotReady[idxIn] <= !transEnable || uopReady || (pwValid && pwMatch(enqAddr));
            end

            if (headClear)
                headValid <= 1'b0;
            if (issueEn) begin
                headValid <= 1'b1;
                slotValid[idxOut] <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (enqEn) begin
            slotAddr[idxIn] <= enqAddr;
            slotSqN[idxIn] <= enqSqN;
        end
        if (issueEn) begin
            headAddr <= slotAddr[idxOut];
            headSqN <= slotSqN[idxOut];
        end
    end

endmodule

//--- rtl/PageWalker.sv
`timescale 1ns/10ps
`include "tlbMiss_config.svh"

module PageWalker (
    input  logic                clk,
    input  logic                rst,
    input  logic                walkStart,
    input  tlbMissPkg::Vpn      walkVpn,
    input  tlbMissPkg::Ppn      rootPpn,
    input  logic                memRespValid,
    input  logic [31:0]         memRespData,
    output logic                memReq,
    output logic [33:0]         memAddr,
    output logic                pwValid,
    output tlbMissPkg::Vpn      pwVpn,
    output tlbMissPkg::Ppn      pwPpn,
    output logic                pwSuperPage,
    output logic                pwActive
);
    tlbMissPkg::WalkState state;

    tlbMissPkg::Vpn vpnReg;
    tlbMissPkg::Ppn ppnReg;
    logic superReg;

    tlbMissPkg::Ppn respPpn;
    logic leaf;
    logic respTaken;

    assign respPpn = memRespData[`TLBMISS_PTE_PPN_LSB +: `TLBMISS_PPN_WIDTH];
    assign leaf = memRespData[`TLBMISS_PTE_R_BIT] || memRespData[`TLBMISS_PTE_X_BIT];
    assign respTaken = memRespValid &&
        (state == tlbMissPkg::LEVEL1_WAIT || state == tlbMissPkg::LEVEL0_WAIT);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= tlbMissPkg::IDLE;
        end else begin
            case (state)
                tlbMissPkg::IDLE: begin
                    if (walkStart)
                        state <= tlbMissPkg::LEVEL1_REQ;
                end
                tlbMissPkg::LEVEL1_REQ: begin
                    state <= tlbMissPkg::LEVEL1_WAIT;
                end
                tlbMissPkg::LEVEL1_WAIT: begin
                    // R or X set means a 4 MiB leaf
                    if (memRespValid)
                        state <= leaf ? tlbMissPkg::DONE : tlbMissPkg::LEVEL0_REQ;
                end
                tlbMissPkg::LEVEL0_REQ: begin
                    state <= tlbMissPkg::LEVEL0_WAIT;
                end
                tlbMissPkg::LEVEL0_WAIT: begin
                    if (memRespValid)
                        state <= tlbMissPkg::DONE;
                end
                tlbMissPkg::DONE: begin
                    state <= tlbMissPkg::IDLE;
                end
                default: begin
                    state <= tlbMissPkg::IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == tlbMissPkg::IDLE && walkStart)
            vpnReg <= walkVpn;
        if (respTaken) begin
            ppnReg <= respPpn;
            superReg <= (state == tlbMissPkg::LEVEL1_WAIT) && leaf;
        end
    end

    assign memReq = (state == tlbMissPkg::LEVEL1_REQ) || (state == tlbMissPkg::LEVEL0_REQ);

    // Level 1 indexes the root table, level 0 the table from the level 1 entry
    assign memAddr = (state == tlbMissPkg::LEVEL0_REQ) ?
        {ppnReg, vpnReg[9:0], 2'b00} :
        {rootPpn, vpnReg[19:10], 2'b00};

    assign pwValid = (state == tlbMissPkg::DONE);
    assign pwActive = (state != tlbMissPkg::IDLE);
    assign pwVpn = vpnReg;
    assign pwPpn = ppnReg;
    assign pwSuperPage = superReg;

endmodule

//--- rtl/MicroTlb.sv
`timescale 1ns/10ps
`include "tlbMiss_config.svh"

module MicroTlb #(
    parameter int SIZE = `TLBMISS_TLB_SIZE
) (
    input  logic            clk,
    input  logic            rst,
    input  tlbMissPkg::Vpn  lookupVpnA,
    input  tlbMissPkg::Vpn  lookupVpnB,
    input  logic            fillValid,
    input  tlbMissPkg::Vpn  fillVpn,
    input  tlbMissPkg::Ppn  fillPpn,
    input  logic            fillSuperPage,
    output logic            hitA,
    output logic            hitB,
    output tlbMissPkg::Ppn  ppnB,
    output logic            superPageB
);
    localparam int IDW = (SIZE > 1) ? $clog2(SIZE) : 1;

    logic [SIZE-1:0] entValid;
    logic [SIZE-1:0] entSuper;
    tlbMissPkg::Vpn entVpn [SIZE];
    tlbMissPkg::Ppn entPpn [SIZE];

    logic [IDW-1:0] rrPtr;
    logic fillHit;
    logic [IDW-1:0] fillHitIdx;
    logic [IDW-1:0] fillIdx;

    // Superpage entries compare vpn[19:10] only
    function automatic logic entryMatch(input int i, input tlbMissPkg::Vpn vpn);
        return entValid[i] &&
            (entSuper[i] ? (entVpn[i][19:10] == vpn[19:10]) : (entVpn[i] == vpn));
    endfunction

    always_comb begin
        hitA = 1'b0;
        hitB = 1'b0;
        ppnB = '0;
        superPageB = 1'b0;
        fillHit = 1'b0;
        fillHitIdx = '0;
        for (int i = 0; i < SIZE; i++) begin
            if (entryMatch(i, lookupVpnA))
                hitA = 1'b1;
            if (entryMatch(i, lookupVpnB)) begin
                hitB = 1'b1;
                ppnB = entPpn[i];
                superPageB = entSuper[i];
            end
            if (entryMatch(i, fillVpn)) begin
                fillHit = 1'b1;
                fillHitIdx = IDW'(i);
            end
        end
    end

    // Refill of a present page reuses its entry
    assign fillIdx = fillHit ? fillHitIdx : rrPtr;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            entValid <= '0;
            rrPtr <= '0;
        end else if (fillValid) begin
            entValid[fillIdx] <= 1'b1;
            if (!fillHit)
                rrPtr <= (rrPtr == IDW'(SIZE - 1)) ? '0 : rrPtr + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (fillValid) begin
            entVpn[fillIdx] <= fillVpn;
            entPpn[fillIdx] <= fillPpn;
            entSuper[fillIdx] <= fillSuperPage;
        end
    end

endmodule

//--- rtl/TlbMissTop.sv
`timescale 1ns/10ps
`include "tlbMiss_config.svh"

module TlbMissTop (
    input  logic            clk,
    input  logic            rst,
    input  logic            inValid,
    input  logic [31:0]     inAddr,
    input  tlbMissPkg::SqN  inSqN,
    output logic            inReady,
    input  logic            branchTaken,
    input  tlbMissPkg::SqN  branchSqN,
    input  logic            transEnable,
    input  tlbMissPkg::Ppn  rootPpn,
    output logic            outValid,
    output logic [33:0]     outPhysAddr,
    output tlbMissPkg::SqN  outSqN,
    input  logic            outAccept,
    output logic            memReq,
    output logic [33:0]     memAddr,
    input  logic            memRespValid,
    input  logic [31:0]     memRespData
);
    localparam int QW = $clog2(`TLBMISS_QUEUE_SIZE);

    logic [QW:0] freeCount;
    logic queueReady;
    logic headValid;
    logic [31:0] headAddr;
    tlbMissPkg::SqN headSqN;

    logic hitA;
    logic hitB;
    tlbMissPkg::Ppn ppnB;
    logic superPageB;

    logic pwValid;
    tlbMissPkg::Vpn pwVpn;
    tlbMissPkg::Ppn pwPpn;
    logic pwSuperPage;
    logic pwActive;

    logic headTranslated;
    logic replay;
    logic walkStart;
    logic dequeue;
    logic enqueue;
    logic [31:0] enqAddr;
    tlbMissPkg::SqN enqSqN;
    logic uopReady;

    // Translator on the head register
    assign headTranslated = !transEnable || hitB;
    assign outValid = headValid && headTranslated;
    assign replay = headValid && !headTranslated;
    assign walkStart = replay && !pwActive;
    assign dequeue = (outValid && outAccept) || replay;
    assign outSqN = headSqN;

    // Superpage keeps vaddr[21:0]
    always_comb begin
        if (!transEnable)
            outPhysAddr = {2'b00, headAddr};
        else if (superPageB)
            outPhysAddr = {ppnB[21:10], headAddr[21:0]};
        else
            outPhysAddr = {ppnB, headAddr[11:0]};
    end

    // Replay wins over a new op
    assign inReady = !replay && (freeCount != '0);
    assign enqueue = replay ? queueReady : (inValid && inReady);
    assign enqAddr = replay ? headAddr : inAddr;
    assign enqSqN = replay ? headSqN : inSqN;
    assign uopReady = !replay && hitA;

    TlbMissQueue queue (
        .clk(clk), .rst(rst),
        .branchTaken(branchTaken), .branchSqN(branchSqN),
        .pwValid(pwValid), .pwVpn(pwVpn), .pwSuperPage(pwSuperPage), .pwActive(pwActive),
        .transEnable(transEnable),
        .enqueue(enqueue), .enqAddr(enqAddr), .enqSqN(enqSqN), .uopReady(uopReady),
        .dequeue(dequeue),
        .freeCount(freeCount), .ready(queueReady),
        .headValid(headValid), .headAddr(headAddr), .headSqN(headSqN)
    );

    PageWalker walker (
        .clk(clk), .rst(rst),
        .walkStart(walkStart), .walkVpn(headAddr[31:12]), .rootPpn(rootPpn),
        .memRespValid(memRespValid), .memRespData(memRespData),
        .memReq(memReq), .memAddr(memAddr),
        .pwValid(pwValid), .pwVpn(pwVpn), .pwPpn(pwPpn),
        .pwSuperPage(pwSuperPage), .pwActive(pwActive)
    );

    MicroTlb tlb (
        .clk(clk), .rst(rst),
        .lookupVpnA(inAddr[31:12]), .lookupVpnB(headAddr[31:12]),
        .fillValid(pwValid), .fillVpn(pwVpn), .fillPpn(pwPpn), .fillSuperPage(pwSuperPage),
        .hitA(hitA), .hitB(hitB), .ppnB(ppnB), .superPageB(superPageB)
    );

endmodule

//--- testbench/tlbMiss_assertions.sv
`timescale 1ns/10ps
`include "tlbMiss_config.svh"

module TlbMissAssertions (
    input  logic                                    clk,
    input  logic                                    rst,
    input  logic                                    inValid,
    input  logic                                    inReady,
    input  logic                                    transEnable,
    input  logic                                    branchTaken,
    input  logic                                    headValid,
    input  logic [$clog2(`TLBMISS_QUEUE_SIZE):0]    freeCount,
    input  logic                                    outValid,
    input  logic                                    outAccept,
    input  logic [33:0]                             outPhysAddr,
    input  tlbMissPkg::SqN                          outSqN,
    input  logic                                    memReq,
    input  logic                                    pwValid,
    input  logic                                    pwActive
);
    int failCount = 0;

    memReqInReset: assert property (@(posedge clk) rst |-> !memReq)
        else begin
            $error("memReq was high during reset");
            failCount++;
        end

    // Memory is only read inside a walk
    memReqInWalk: assert property (@(posedge clk) disable iff (rst) memReq |-> pwActive)
        else begin
            $error("memReq pulsed while no walk was active");
            failCount++;
        end

    pwValidPulse: assert property (@(posedge clk) disable iff (rst)
        pwValid |-> pwActive ##1 !pwValid)
        else begin
            $error("pwValid was not a single pulse inside an active walk");
            failCount++;
        end

    // Held output must not move until the consumer takes it
    outputHeld: assert property (@(posedge clk) disable iff (rst)
        outValid && !outAccept && !branchTaken |=>
            outValid && $stable(outPhysAddr) && $stable(outSqN))
        else begin
            $error("Output changed while outAccept was low");
            failCount++;
        end

    // Two edges from enqueue to output on an empty unit with translation off
    emptyLatency: assert property (@(posedge clk) disable iff (rst)
        inValid && inReady && !transEnable && !headValid && !branchTaken &&
            freeCount == `TLBMISS_QUEUE_SIZE |-> ##1 !outValid ##1 outValid)
        else begin
            $error("Op did not reach the output two edges after enqueue");
            failCount++;
        end

endmodule

bind TlbMissTop TlbMissAssertions propCheck (
    .clk(clk), .rst(rst),
    .inValid(inValid), .inReady(inReady),
    .transEnable(transEnable), .branchTaken(branchTaken),
    .headValid(headValid), .freeCount(freeCount),
    .outValid(outValid), .outAccept(outAccept),
    .outPhysAddr(outPhysAddr), .outSqN(outSqN),
    .memReq(memReq), .pwValid(pwValid), .pwActive(pwActive)
);

//--- testbench/TlbMissTb.sv
`timescale 1ns/10ps

module TlbMissTb;
    localparam logic [21:0] ROOT_PPN = 22'h000100;
    localparam int SQN_RANGE = 2 ** $bits(tlbMissPkg::SqN);
    localparam int TOTAL_OPS = 40;

    logic clk;
    logic rst;
    logic inValid;
    logic [31:0] inAddr;
    tlbMissPkg::SqN inSqN;
    logic inReady;
    logic branchTaken;
    tlbMissPkg::SqN branchSqN;
    logic transEnable;
    tlbMissPkg::Ppn rootPpn;
    logic outValid;
    logic [33:0] outPhysAddr;
    tlbMissPkg::SqN outSqN;
    logic outAccept;
    logic memReq;
    logic [33:0] memAddr;
    logic memRespValid;
    logic [31:0] memRespData;

    // Scoreboard indexed by sequence number
    logic [33:0] expAddr [SQN_RANGE];
    bit pending [SQN_RANGE];
    int outstanding = 0;
    int reqCount = 0;
    tlbMissPkg::SqN nextSqN = '0;
    bit holdAccept = 1'b0;
    bit randomAccept = 1'b1;

    TlbMissTop UUT (
        .clk(clk), .rst(rst),
        .inValid(inValid), .inAddr(inAddr), .inSqN(inSqN), .inReady(inReady),
        .branchTaken(branchTaken), .branchSqN(branchSqN),
        .transEnable(transEnable), .rootPpn(rootPpn),
        .outValid(outValid), .outPhysAddr(outPhysAddr), .outSqN(outSqN),
        .outAccept(outAccept),
        .memReq(memReq), .memAddr(memAddr),
        .memRespValid(memRespValid), .memRespData(memRespData)
    );

    always #50 clk = ~clk;

    task automatic failRun();
        $display("ERRORS FOUND");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    // 4 KiB pages map to vpn + 22'h10000
    // Values of vpn[19:10] below 4 are 4 MiB pages
    function automatic logic [33:0] expectedPhys(input logic [31:0] va, input logic trans);
        logic [11:0] superPpn;
        logic [21:0] pagePpn;
        superPpn = {2'b00, va[31:22]} + 12'h040;
        pagePpn = {2'b00, va[31:12]} + 22'h10000;
        if (!trans)
            return {2'b00, va};
        else if (va[31:22] < 10'd4)
            return {superPpn, va[21:0]};
        else
            return {pagePpn, va[11:0]};
    endfunction

    // Level 0 tables sit at ppn {12'h002, vpn[19:10]}
    function automatic logic [31:0] pteAt(input logic [33:0] addr);
        logic [11:0] superPpn;
        logic [21:0] pagePpn;
        superPpn = {2'b00, addr[11:2]} + 12'h040;
        pagePpn = {2'b00, addr[21:12], addr[11:2]} + 22'h10000;
        if (addr[33:12] == ROOT_PPN && addr[11:2] < 10'd4)
            return {superPpn, 10'h000, 10'h003};
        else if (addr[33:12] == ROOT_PPN)
            return {12'h002, addr[11:2], 10'h001};
        else
            return {pagePpn, 10'h003};
    endfunction

    initial begin : memoryModel
        logic [33:0] reqAddr;
        int delay;
        forever begin
            if (memReq === 1'b1) begin
                reqAddr = memAddr;
                reqCount++;
                assert (reqAddr[33:12] == ROOT_PPN || reqAddr[33:22] == 12'h002)
                else begin
                    $display("Page walker read outside the page table at %h", reqAddr);
                    failRun();
                end
                delay = 1 + ($urandom % 4);
                repeat (delay) @(negedge clk);
                memRespData = pteAt(reqAddr);
                memRespValid = 1'b1;
                @(negedge clk);
                memRespValid = 1'b0;
            end else begin
                @(negedge clk);
            end
        end
    end

    always @(negedge clk) begin
        if (holdAccept)
            outAccept = 1'b0;
        else if (randomAccept)
            outAccept = ($urandom % 4) != 0;
        else
            outAccept = 1'b1;
    end

    always @(posedge clk) begin
        if (!rst && outValid && outAccept) begin
            assert (pending[outSqN])
            else begin
                $display("Op %h came out although it was flushed or delivered", outSqN);
                failRun();
            end
            assert (outPhysAddr == expAddr[outSqN])
            else begin
                $display("CHECK FAILED outPhysAddr: expected %h, got %h (outSqN %h)",
                    expAddr[outSqN], outPhysAddr, outSqN);
                failRun();
            end
            pending[outSqN] = 1'b0;
            outstanding--;
        end
    end

    always @(negedge clk) begin
        if (UUT.propCheck.failCount != 0) begin
            $display("A bound assertion on the unit failed");
            failRun();
        end
    end

    initial begin : watchdog
        repeat (TOTAL_OPS * 200 + 1000) @(posedge clk);
        $display("Timeout: the tests did not finish in time");
        failRun();
    end

    task automatic sendOp(input logic [31:0] addr);
        @(negedge clk);
        inValid = 1'b1;
        inAddr = addr;
        inSqN = nextSqN;
        while (!inReady)
            @(negedge clk);
        expAddr[nextSqN] = expectedPhys(addr, transEnable);
        pending[nextSqN] = 1'b1;
        outstanding++;
        nextSqN++;
        @(posedge clk);
    endtask

    task automatic stopSending();
        @(negedge clk);
        inValid = 1'b0;
    endtask

    task automatic drain();
        while (outstanding != 0)
            @(negedge clk);
        @(posedge clk);
    endtask

    // Younger means a positive signed distance from the branch
    task automatic branchFlush(input tlbMissPkg::SqN bSqN);
        tlbMissPkg::SqN diff;
        @(posedge clk);
        holdAccept = 1'b1;
        @(negedge clk);
        branchTaken = 1'b1;
        branchSqN = bSqN;
        @(posedge clk);
        for (int i = 0; i < SQN_RANGE; i++) begin
            diff = tlbMissPkg::SqN'(i) - bSqN;
            if (pending[i] && $signed(diff) > 0) begin
                pending[i] = 1'b0;
                outstanding--;
            end
        end
        nextSqN = bSqN + 1'b1;
        holdAccept = 1'b0;
        @(negedge clk);
        branchTaken = 1'b0;
    endtask

    initial begin
        tlbMissPkg::SqN firstSqN;
        int reqBefore;
        void'($urandom(32'h57dc));
        clk = 1'b0;
        rst = 1'b1;
        inValid = 1'b0;
        inAddr = '0;
        inSqN = '0;
        branchTaken = 1'b0;
        branchSqN = '0;
        transEnable = 1'b0;
        rootPpn = ROOT_PPN;
        outAccept = 1'b0;
        memRespValid = 1'b0;
        memRespData = '0;
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        // Translation off
        for (int i = 0; i < 8; i++)
            sendOp($urandom);
        stopSending();
        drain();
        randomAccept = 1'b0;

        // Cold TLB, three 4 KiB pages, then a second round without walks
        @(negedge clk);
        transEnable = 1'b1;
        for (int r = 0; r < 2; r++)
            for (int p = 0; p < 3; p++)
                sendOp(32'h1000_0000 + p * 32'h0040_3000 + r * 32'h128);
        stopSending();
        drain();
        reqBefore = reqCount;
        for (int p = 0; p < 3; p++)
            sendOp(32'h1000_0a40 + p * 32'h0040_3000);
        stopSending();
        drain();
        assert (reqCount == reqBefore)
        else begin
            $display("Page walk repeated for a page already in the TLB");
            failRun();
        end

        // Superpage regions 1 and 2, one walk each
        reqBefore = reqCount;
        for (int i = 0; i < 6; i++)
            sendOp({10'(1 + i % 2), 22'($urandom)});
        stopSending();
        drain();
        assert (reqCount - reqBefore == 2)
        else begin
            $display("Superpage regions took %0d memory reads", reqCount - reqBefore);
            failRun();
        end

        for (int r = 0; r < 3; r++) begin
            firstSqN = nextSqN;
            for (int i = 0; i < 4; i++)
                sendOp($urandom);
            stopSending();
            branchFlush(firstSqN - 1'b1 + tlbMissPkg::SqN'($urandom % 4));
            drain();
        end

        // Back-pressure on a warm page until queue and head are full
        sendOp(32'h1234_5678);
        stopSending();
        drain();
        holdAccept = 1'b1;
        for (int i = 0; i < 4; i++)
            sendOp(32'h1234_5000 + i * 16);
        stopSending();
        assert (!inReady)
        else begin
            $display("inReady stayed high with the queue and head full");
            failRun();
        end
        repeat (3) @(posedge clk);
        holdAccept = 1'b0;
        drain();

        repeat (5) @(posedge clk);
        if (UUT.propCheck.failCount != 0) begin
            $display("A bound assertion on the unit failed");
            failRun();
        end else begin
            $display("NO ERRORS");
            $finish;
        end
    end

endmodule

//--- verilog.f
+incdir+rtl
rtl/tlbMissPkg.sv
rtl/TlbMissQueue.sv
rtl/PageWalker.sv
rtl/MicroTlb.sv
rtl/TlbMissTop.sv
testbench/tlbMiss_assertions.sv
testbench/TlbMissTb.sv

//--- Bender.yml
package:
  name: tlb_miss

export_include_dirs:
  - rtl

sources:
  - files:
      - rtl/tlbMissPkg.sv
      - rtl/TlbMissQueue.sv
      - rtl/PageWalker.sv
      - rtl/MicroTlb.sv
      - rtl/TlbMissTop.sv
  - target: test
    files:
      - testbench/tlbMiss_assertions.sv
      - testbench/TlbMissTb.sv
